//--- Makefile
# Verilator build and run of the KD-tree engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module kd_tb -f tb.f

# Fails unless the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/Vkd_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

//--- common/kd_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes of the KD-tree search engine, shared by package, RTL and testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef KD_DEFS_SVH
`define KD_DEFS_SVH

// Tree shape
`define KD_DEPTH   6    // Internal levels
`define KD_NODES   63   // Internal split nodes
`define KD_LEAVES  64   // Leaves below the last level

// Patch layout
`define KD_DIMS    5    // Components per patch
`define KD_COMP_W  11   // Width of one component
`define KD_DIM_W   3    // Component index width

// Tags and addresses
`define KD_LEAF_W  6    // Leaf index width
`define KD_LTAG_W  16   // Stored leaf tag, also the load word width
`define KD_QTAG_W  8    // Tag carried with each query
`define KD_ADDR_W  7    // Load address, nodes then leaves

`endif

//--- common/kd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Struct types for the KD-tree engine, used by scoped name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "kd_defs.svh"

package kd_pkg;

  // Split rule of one internal node, 14 bits
  typedef struct packed {
    logic [`KD_DIM_W-1:0]  dim;     // Component to compare
    logic [`KD_COMP_W-1:0] thresh;  // Right child when component >= thresh
  } kd_node_t;

  // Query patch, component 0 in the low bits
  typedef logic [`KD_DIMS-1:0][`KD_COMP_W-1:0] kd_patch_t;

  // Patch plus the host's own tag, 63 bits
  typedef struct packed {
    kd_patch_t              patch;
    logic [`KD_QTAG_W-1:0]  qtag;
  } kd_query_t;

  // One load word with its address, 23 bits
  // Node words use the low 14 data bits as a kd_node_t
  typedef struct packed {
    logic [`KD_ADDR_W-1:0]  addr;
    logic [`KD_LTAG_W-1:0]  data;
  } kd_load_t;

  // Query contents held between two tree levels
  typedef struct packed {
    kd_query_t              q;
    logic [`KD_LEAVES-1:0]  act;  // One-hot active node, low bits only on upper levels
  } kd_stage_t;

  // Tree output towards the leaf store, 14 bits
  typedef struct packed {
    logic [`KD_QTAG_W-1:0]  qtag;
    logic [`KD_LEAF_W-1:0]  leaf;
  } kd_hit_t;

  // Final answer to the host, 30 bits
  typedef struct packed {
    logic [`KD_QTAG_W-1:0]  qtag;
    logic [`KD_LEAF_W-1:0]  leaf;
    logic [`KD_LTAG_W-1:0]  ltag;
  } kd_result_t;

endpackage

//--- kd_tree/kd_internal_node.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One split node of the tree; steers a valid to its left or right child
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_internal_node (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,           // Load strobe for this node only
  input  kd_pkg::kd_node_t  wdata,
  input  kd_pkg::kd_patch_t patch,        // Patch of the query at this level
  input  logic              valid_in,     // Query has reached this node
  output logic              valid_left,
  output logic              valid_right
);

  kd_pkg::kd_node_t       node_q;         // Stored split rule
  logic [`KD_COMP_W-1:0]  comp;           // Selected component
  logic                   dim_ok;
  logic                   go_right;

  // Split rule register, loaded by the host
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_q <= '0;
    end else if (we) begin
      node_q <= wdata;
    end
  end

  // Component mux
  // An index past the last component reads as zero
  assign dim_ok = node_q.dim < `KD_DIM_W'(`KD_DIMS);
  assign comp   = dim_ok ? patch[node_q.dim] : '0;

  assign go_right = comp >= node_q.thresh;  // Ties go right

  assign valid_left  = valid_in && !go_right;
  assign valid_right = valid_in && go_right;

  // A query only meets split rules that name a real component
  a_one_child: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_in |-> dim_ok && !(valid_left && valid_right)
  ) else $error("query reached a node with component index %0d", node_q.dim);

endmodule

//--- kd_tree/kd_node_tree.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Six pipelined levels of split nodes, one register per level
// Gives the leaf index and query tag 6 cycles after query_go
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_node_tree (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              node_we,
  input  kd_pkg::kd_load_t  node_wr,    // Address is the breadth-first node number
  input  logic              query_go,   // Accepted query this cycle
  input  kd_pkg::kd_query_t query,
  output logic              hit_valid,
  output kd_pkg::kd_hit_t   hit
);

  localparam int NODE_W = $bits(kd_pkg::kd_node_t);

  kd_pkg::kd_node_t       node_word;              // Split rule from the load word
  logic [`KD_NODES-1:0]   node_sel;               // One-hot write enable
  kd_pkg::kd_stage_t      stage_in;               // Query entering level 0
  kd_pkg::kd_stage_t      stage_q [1:`KD_DEPTH];  // Level output registers
  wire  [`KD_LEAVES-1:0]  child_v [`KD_DEPTH];    // Child valids of each level
  logic [`KD_LEAF_W-1:0]  leaf_enc;

  assign node_word = kd_pkg::kd_node_t'(node_wr.data[NODE_W-1:0]);

  // Address decoder, one enable per node
  always_comb begin
    node_sel = '0;
    for (int k = 0; k < `KD_NODES; k++) begin
      node_sel[k] = node_we && (node_wr.addr == `KD_ADDR_W'(k));
    end
  end

  // Root is active whenever a query is accepted
  assign stage_in.q   = query;
  assign stage_in.act = `KD_LEAVES'(query_go);

  for (genvar i = 0; i < `KD_DEPTH; i++) begin : g_level
    kd_pkg::kd_stage_t lvl_in;  // What this level sees

    if (i == 0) begin : g_root
      assign lvl_in = stage_in;  // Level 0 straight from the query
    end else begin : g_inner
      assign lvl_in = stage_q[i];
    end

    // Node j of level i has breadth-first number 2^i - 1 + j
    for (genvar j = 0; j < (1 << i); j++) begin : g_node
      kd_internal_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (node_sel[(1 << i) - 1 + j]),
        .wdata       (node_word),
        .patch       (lvl_in.q.patch),
        .valid_in    (lvl_in.act[j]),
        .valid_left  (child_v[i][2*j]),
        .valid_right (child_v[i][2*j+1])
      );
    end

    // Unused child slots on the narrow levels
    if (i < `KD_DEPTH - 1) begin : g_pad
      assign child_v[i][`KD_LEAVES-1:(2 << i)] = '0;
    end

    // Level register, only the active vector is reset
    always_ff @(posedge clk) begin
      stage_q[i+1].q <= lvl_in.q;
      if (!rst_n) begin
        stage_q[i+1].act <= '0;
      end else begin
        stage_q[i+1].act <= child_v[i];
      end
    end

    // At most one node per level holds a given query
    a_act_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(stage_q[i+1].act)
    ) else $error("level %0d active vector not one-hot", i);
  end

  // Leaf encoder, OR of the set position, fine for a one-hot input
  always_comb begin
    leaf_enc = '0;
    for (int k = 0; k < `KD_LEAVES; k++) begin
      if (stage_q[`KD_DEPTH].act[k]) begin
        leaf_enc = leaf_enc | `KD_LEAF_W'(k);
      end
    end
  end

  // Output register, sixth cycle after query_go
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= |stage_q[`KD_DEPTH].act;
    end
  end

  always_ff @(posedge clk) begin
    hit.qtag <= stage_q[`KD_DEPTH].q.qtag;
    hit.leaf <= leaf_enc;
  end

  // Leaf words must never reach the node decoder
  a_node_addr: assert property (
    @(posedge clk) disable iff (!rst_n)
    node_we |-> node_wr.addr < `KD_ADDR_W'(`KD_NODES)
  ) else $error("node write to address %0d", node_wr.addr);

endmodule

//--- sim/kd_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the KD-tree engine, loads random trees and checks every result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_tb;

  // About 800 cycles of tests, a wide margin on top
  localparam int MAX_CYCLES = 3000;
  localparam int NWORDS     = `KD_NODES + `KD_LEAVES;

  logic clk = 1'b0;
  logic rst_n;
  logic load_start, load_valid, query_valid;
  logic [`KD_LTAG_W-1:0] load_data;
  kd_pkg::kd_query_t     query;
  logic ready, query_reject, result_valid;
  kd_pkg::kd_result_t    result;

  logic [`KD_DIM_W-1:0]  ref_dim [`KD_NODES];   // Copy of the loaded tree
  logic [`KD_COMP_W-1:0] ref_thr [`KD_NODES];
  logic [`KD_LTAG_W-1:0] ref_tag [`KD_LEAVES];

  kd_pkg::kd_result_t exp_res_q [$];  // Expected results in order
  int                 exp_due_q [$];  // Cycle each one is due
  kd_pkg::kd_result_t head_res;
  int                 head_due;
  logic               head_valid = 1'b0;
  logic               exp_ready = 1'b0;   // Ready as the load sequence predicts
  logic               exp_reject;
  logic [31:0]        lfsr = 32'ha867_95b2;
  logic [`KD_QTAG_W-1:0] qtag_seq = '0;
  int cyc = 0;
  int err_cnt = 0;
  int test_cnt = 0;
  int pass_cnt = 0;

  always #2 clk = ~clk;  // 4 ns period

  kd_search_top dut (.*);

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Tree walk: right on component >= threshold, node n has children 2n+1 and 2n+2
  function automatic logic [`KD_LEAF_W-1:0] ref_leaf(input kd_pkg::kd_patch_t p);
    int n;
    n = 0;
    for (int l = 0; l < `KD_DEPTH; l++) begin
      n = 2 * n + 1 + ((p[ref_dim[n]] >= ref_thr[n]) ? 1 : 0);
    end
    return `KD_LEAF_W'(n - `KD_NODES);
  endfunction

  // Put the component of the node met at this level right on its threshold
  function automatic kd_pkg::kd_patch_t make_tie(input kd_pkg::kd_patch_t p, input int level);
    kd_pkg::kd_patch_t t;
    int n;
    t = p;
    n = 0;
    for (int l = 0; l < level; l++) begin
      n = 2 * n + 1 + ((t[ref_dim[n]] >= ref_thr[n]) ? 1 : 0);
    end
    t[ref_dim[n]] = ref_thr[n];
    return t;
  endfunction

  function automatic kd_pkg::kd_query_t rand_query();
    kd_pkg::kd_query_t q;
    for (int d = 0; d < `KD_DIMS; d++) begin
      q.patch[d] = `KD_COMP_W'(take_bits(`KD_COMP_W));
    end
    q.qtag   = qtag_seq;  // Running tag, shows order slips
    qtag_seq = qtag_seq + 1'b1;
    return q;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs();
    load_start  = 1'b0;
    load_valid  = 1'b0;
    query_valid = 1'b0;
  endtask

  // Drives a query for this cycle; only an accepted one gets an expected result
  task automatic send_query(input kd_pkg::kd_query_t q);
    kd_pkg::kd_result_t r;
    int accept;
    query_valid = 1'b1;
    query       = q;
    if (exp_ready) begin
      accept = cyc + 1;  // Edge that samples it
      r.qtag = q.qtag;
      r.leaf = ref_leaf(q.patch);
      r.ltag = ref_tag[r.leaf];
      exp_res_q.push_back(r);
      exp_due_q.push_back(accept + 7);
    end
  endtask

  task automatic wait_drain();
    while (exp_res_q.size() > 0) step();
    repeat (2) step();
  endtask

  // load_start, then 63 node words and 64 leaf tags with random gaps
  task automatic load_tree(input bit with_queries);
    kd_pkg::kd_node_t nd;
    idle_inputs();
    load_start = 1'b1;
    step();
    idle_inputs();
    exp_ready = 1'b0;  // Ready drops one cycle after load_start
    for (int a = 0; a < NWORDS; a++) begin
      if (take_bits(2) == 0) begin  // Idle cycle between words
        if (with_queries) send_query(rand_query());
        step();
        idle_inputs();
      end
      if (a < `KD_NODES) begin
        ref_dim[a] = `KD_DIM_W'(take_bits(3) % `KD_DIMS);
        ref_thr[a] = `KD_COMP_W'(take_bits(`KD_COMP_W));
        nd = '{dim: ref_dim[a], thresh: ref_thr[a]};
        load_data = `KD_LTAG_W'(nd);
      end else begin
        ref_tag[a - `KD_NODES] = `KD_LTAG_W'(take_bits(`KD_LTAG_W));
        load_data = ref_tag[a - `KD_NODES];
      end
      load_valid = 1'b1;
      if (with_queries && take_bits(3) == 0) send_query(rand_query());
      step();
      idle_inputs();
    end
    exp_ready = 1'b1;  // One cycle after the last word
  endtask

  task automatic run_burst(input int count);
    kd_pkg::kd_query_t q;
    for (int i = 0; i < count; i++) begin
      q = rand_query();
      if (i % 8 == 3) q.patch = make_tie(q.patch, (i / 8) % `KD_DEPTH);
      send_query(q);
      step();
    end
    idle_inputs();
    wait_drain();
  endtask

  task automatic report_test(input int num, input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      pass_cnt++;
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: %0d check errors", num, name, err_cnt - errs_at_start);
    end
  endtask

  // Cycle count and expected-result head, popped when a result shows up
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (result_valid && exp_res_q.size() > 0) begin
      void'(exp_res_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    head_valid <= exp_res_q.size() > 0;
    if (exp_res_q.size() > 0) begin
      head_res <= exp_res_q[0];
      head_due <= exp_due_q[0];
    end
  end

  // Reject follows a refused query by one cycle
  always @(posedge clk) begin
    if (!rst_n) exp_reject <= 1'b0;
    else        exp_reject <= query_valid && !exp_ready;
  end

  always @(posedge clk) begin
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cyc);
      $display("Test failures found");
      $finish;
    end
  end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ready == exp_ready)
    else begin
      err_cnt++;
      $display("FAIL %0t: ready is %0b, expected %0b", $time, $sampled(ready),
               $sampled(exp_ready));
    end

  a_reject: assert property (@(posedge clk) disable iff (!rst_n) query_reject == exp_reject)
    else begin
      err_cnt++;
      $display("FAIL %0t: query_reject is %0b, expected %0b", $time,
               $sampled(query_reject), $sampled(exp_reject));
    end

  // Result strobe exactly on the due cycle and never otherwise
  a_res_time: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid == (head_valid && cyc == head_due))
    else begin
      err_cnt++;
      $display("FAIL %0t: result_valid %0b at cycle %0d, next due %0d", $time,
               $sampled(result_valid), $sampled(cyc), $sampled(head_due));
    end

  a_res_data: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result == head_res)
    else begin
      err_cnt++;
      $display("FAIL %0t: result %h, expected %h", $time, $sampled(result),
               $sampled(head_res));
    end

  initial begin
    int e;
    rst_n = 1'b0;
    idle_inputs();
    load_data = '0;
    query     = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e = err_cnt;  // Refused query before any load
    repeat (2) step();
    send_query(rand_query());
    step();
    idle_inputs();
    repeat (10) step();
    report_test(1, "reset_reject", e);

    e = err_cnt;
    load_tree(1'b0);
    repeat (3) step();
    report_test(2, "full_load", e);

    e = err_cnt;  // Isolated queries with random gaps
    for (int i = 0; i < 20; i++) begin
      send_query(rand_query());
      step();
      idle_inputs();
      wait_drain();
      repeat (take_bits(2)) step();
    end
    report_test(3, "single_queries", e);

    e = err_cnt;
    run_burst(200);
    report_test(4, "burst_ties", e);

    e = err_cnt;  // New tree, queries thrown in while it loads
    load_tree(1'b1);
    run_burst(60);
    report_test(5, "reload", e);

    repeat (5) step();
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == test_cnt) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- src/kd_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load sequencing and query admission for the engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_start,    // Restarts loading from word 0
  input  logic                   load_valid,
  input  logic [`KD_LTAG_W-1:0]  load_data,
  input  logic                   query_valid,
  output logic                   ready,         // Tree fully loaded
  output logic                   query_reject,
  output logic                   query_go,
  output logic                   node_we,
  output kd_pkg::kd_load_t       node_wr,
  output logic                   leaf_we,
  output kd_pkg::kd_load_t       leaf_wr
);

  localparam logic [`KD_ADDR_W-1:0] LAST_NODE = `KD_ADDR_W'(`KD_NODES - 1);
  localparam logic [`KD_ADDR_W-1:0] LAST_WORD = `KD_ADDR_W'(`KD_NODES + `KD_LEAVES - 1);

  typedef enum logic [1:0] {
    IDLE,
    LOAD_NODES,
    LOAD_LEAVES,
    READY
  } state_t;

  state_t                  state;
  logic [`KD_ADDR_W-1:0]   addr;      // Next load word
  logic                    wr_word;   // A word is taken this cycle
  kd_pkg::kd_load_t        load_word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= IDLE;
      addr         <= '0;
      query_reject <= 1'b0;
    end else begin
      query_reject <= query_valid && !ready;  // One cycle after the refused query
      if (load_start) begin
        state <= LOAD_NODES;
        addr  <= '0;
      end else if (load_valid) begin
        case (state)
          LOAD_NODES: begin
            addr <= addr + 1'b1;
            if (addr == LAST_NODE) state <= LOAD_LEAVES;
          end
          LOAD_LEAVES: begin
            if (addr == LAST_WORD) begin
              state <= READY;  // Counter parks on the last word
            end else begin
              addr <= addr + 1'b1;
            end
          end
          default: ;  // Loose words in IDLE and READY are dropped
        endcase
      end
    end
  end

  assign ready    = state == READY;
  assign query_go = query_valid && ready;

  // Write steering, load_start wins over a word in the same cycle
  assign wr_word   = load_valid && !load_start;
  assign load_word = '{addr: addr, data: load_data};

  assign node_we = wr_word && state == LOAD_NODES;
  assign node_wr = load_word;
  assign leaf_we = wr_word && state == LOAD_LEAVES;
  assign leaf_wr = load_word;

  // Counter stays inside the part being loaded
  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == LOAD_NODES  |-> addr <= LAST_NODE) and
    (state == LOAD_LEAVES |-> addr >  LAST_NODE && addr <= LAST_WORD)
  ) else $error("load address %0d out of range", addr);

  // Queries enter only once all 127 words have been taken
  a_go_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    query_go |-> ready && addr == LAST_WORD
  ) else $error("query admitted before the tree was loaded");

endmodule

//--- src/kd_leaf_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Leaf tag registers with a registered lookup by leaf index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_leaf_store (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               leaf_we,
  input  kd_pkg::kd_load_t   leaf_wr,      // Address 63..126, leaf = addr - 63
  input  logic               hit_valid,
  input  kd_pkg::kd_hit_t    hit,
  output logic               result_valid,
  output kd_pkg::kd_result_t result
);

  localparam logic [`KD_ADDR_W-1:0] LEAF_BASE = `KD_ADDR_W'(`KD_NODES);
  localparam logic [`KD_ADDR_W-1:0] LEAF_LAST = `KD_ADDR_W'(`KD_NODES + `KD_LEAVES - 1);

  logic [`KD_LTAG_W-1:0]  tags [`KD_LEAVES];
  logic [`KD_LEAF_W-1:0]  wr_idx;

  assign wr_idx = `KD_LEAF_W'(leaf_wr.addr - LEAF_BASE);

  // Tag file
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `KD_LEAVES; k++) begin
        tags[k] <= '0;
      end
    end else if (leaf_we) begin
      tags[wr_idx] <= leaf_wr.data;
    end
  end

  // Lookup stage, one cycle behind the tree
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= hit_valid;
    end
  end

  always_ff @(posedge clk) begin
    result.qtag <= hit.qtag;
    result.leaf <= hit.leaf;
    result.ltag <= tags[hit.leaf];
  end

  // Controller must only send the leaf half of the load here
  a_leaf_addr: assert property (
    @(posedge clk) disable iff (!rst_n)
    leaf_we |-> leaf_wr.addr >= LEAF_BASE && leaf_wr.addr <= LEAF_LAST
  ) else $error("leaf write to address %0d", leaf_wr.addr);

endmodule

//--- src/kd_search_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine top, control plus tree plus leaf store
// Load 127 words after load_start, then stream queries while ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "kd_defs.svh"

module kd_search_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_start,
  input  logic                   load_valid,
  input  logic [`KD_LTAG_W-1:0]  load_data,
  input  logic                   query_valid,
  input  kd_pkg::kd_query_t      query,
  output logic                   ready,
  output logic                   query_reject,
  output logic                   result_valid,   // 7 cycles after acceptance
  output kd_pkg::kd_result_t     result
);

  logic              query_go;
  logic              node_we;
  kd_pkg::kd_load_t  node_wr;
  logic              leaf_we;
  kd_pkg::kd_load_t  leaf_wr;
  logic              hit_valid;
  kd_pkg::kd_hit_t   hit;

  kd_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_start   (load_start),
    .load_valid   (load_valid),
    .load_data    (load_data),
    .query_valid  (query_valid),
    .ready        (ready),
    .query_reject (query_reject),
    .query_go     (query_go),
    .node_we      (node_we),
    .node_wr      (node_wr),
    .leaf_we      (leaf_we),
    .leaf_wr      (leaf_wr)
  );

  // Query payload goes straight to level 0
  kd_node_tree u_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .node_we   (node_we),
    .node_wr   (node_wr),
    .query_go  (query_go),
    .query     (query),
    .hit_valid (hit_valid),
    .hit       (hit)
  );

  kd_leaf_store u_leaves (
    .clk          (clk),
    .rst_n        (rst_n),
    .leaf_we      (leaf_we),
    .leaf_wr      (leaf_wr),
    .hit_valid    (hit_valid),
    .hit          (hit),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

//--- tb.f
+incdir+common
common/kd_pkg.sv
kd_tree/kd_internal_node.sv
kd_tree/kd_node_tree.sv
src/kd_ctrl.sv
src/kd_leaf_store.sv
src/kd_search_top.sv
sim/kd_tb.sv
